//--- src/core_pkg.sv
package core_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // data, address and instruction words share one width
    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

endpackage

//--- src/isa_pkg.sv
package isa_pkg;

    typedef logic [4:0] opcode_t;
    typedef logic [4:0] alu_op_t;

    localparam opcode_t OP_ALU  = 5'd0;
    localparam opcode_t OP_J    = 5'd1;
    localparam opcode_t OP_BNE  = 5'd2;
    localparam opcode_t OP_JAL  = 5'd3;
    localparam opcode_t OP_JR   = 5'd4;
    localparam opcode_t OP_ADDI = 5'd5;
    localparam opcode_t OP_BLT  = 5'd6;
    localparam opcode_t OP_SW   = 5'd7;
    localparam opcode_t OP_LW   = 5'd8;

    localparam alu_op_t ALU_ADD = 5'd0;
    localparam alu_op_t ALU_SUB = 5'd1;
    localparam alu_op_t ALU_AND = 5'd2;
    localparam alu_op_t ALU_OR  = 5'd3;
    localparam alu_op_t ALU_SLL = 5'd4;
    localparam alu_op_t ALU_SRA = 5'd5;

    // instruction fields, msb and lsb
    localparam int OPCODE_HI = 31;
    localparam int OPCODE_LO = 27;
    localparam int RD_HI     = 26;
    localparam int RD_LO     = 22;
    localparam int RS_HI     = 21;
    localparam int RS_LO     = 17;
    localparam int RT_HI     = 16;
    localparam int RT_LO     = 12;
    localparam int SHAMT_HI  = 11;
    localparam int SHAMT_LO  = 7;
    localparam int ALUOP_HI  = 6;
    localparam int ALUOP_LO  = 2;
    localparam int IMM_HI    = 16;
    localparam int IMM_LO    = 0;
    localparam int TARGET_HI = 26;
    localparam int TARGET_LO = 0;

    localparam logic [4:0]  REG_ZERO  = 5'd0;
    localparam logic [4:0]  REG_LINK  = 5'd31;  // jal return address
    localparam logic [31:0] NOP_INSTR = 32'h0000_0000;  // add r0 r0 r0

endpackage

//--- src/alu.sv
`timescale 1ns/100ps

module alu (
    input  core_pkg::word_t operand_a_i,
    input  core_pkg::word_t operand_b_i,
    input  isa_pkg::alu_op_t alu_op_i,
    input  logic [4:0]      shamt_i,
    output core_pkg::word_t result_o,
    output logic            not_equal_o,
    output logic            less_than_o
);
    import core_pkg::*;
    import isa_pkg::*;

    logic signed [WORD_W-1:0] a_signed;
    logic signed [WORD_W-1:0] b_signed;

    assign a_signed = operand_a_i;
    assign b_signed = operand_b_i;

    always_comb begin
        case (alu_op_i)
            ALU_ADD: result_o = operand_a_i + operand_b_i;
            ALU_SUB: result_o = operand_a_i - operand_b_i;
            ALU_AND: result_o = operand_a_i & operand_b_i;
            ALU_OR:  result_o = operand_a_i | operand_b_i;
            ALU_SLL: result_o = operand_a_i << shamt_i;
            ALU_SRA: result_o = word_t'(a_signed >>> shamt_i);  // keeps sign bit
            default: result_o = '0;
        endcase
    end

    assign not_equal_o = (operand_a_i != operand_b_i);
    assign less_than_o = (a_signed < b_signed);

endmodule

//--- src/operand_bypass.sv
`timescale 1ns/100ps

module operand_bypass (
    input  core_pkg::word_t     reg_val_i,
    input  core_pkg::reg_addr_t reg_num_i,
    input  core_pkg::word_t     xm_ir_i,
    input  core_pkg::word_t     xm_o_i,
    input  core_pkg::reg_addr_t mw_rd_i,
    input  core_pkg::word_t     mw_data_i,
    input  logic                mw_wren_i,
    output core_pkg::word_t     operand_o
);
    import core_pkg::*;
    import isa_pkg::*;

    opcode_t   xm_opcode;
    reg_addr_t xm_dest;
    logic      xm_writes;
    logic      use_xm;
    logic      use_mw;

    assign xm_opcode = xm_ir_i[OPCODE_HI:OPCODE_LO];
    assign xm_dest   = (xm_opcode == OP_JAL) ? REG_LINK : xm_ir_i[RD_HI:RD_LO];
    assign xm_writes = (xm_opcode == OP_ALU) || (xm_opcode == OP_ADDI) ||
                       (xm_opcode == OP_JAL) || (xm_opcode == OP_LW);

    assign use_xm = xm_writes && (xm_dest == reg_num_i) && (reg_num_i != REG_ZERO);
    assign use_mw = mw_wren_i && (mw_rd_i == reg_num_i) && (reg_num_i != REG_ZERO);

    assign operand_o = use_xm ? xm_o_i : (use_mw ? mw_data_i : reg_val_i);  // newest first

endmodule

//--- src/hazard_detect.sv
`timescale 1ns/100ps

module hazard_detect (
    input  core_pkg::word_t fd_ir_i,
    input  core_pkg::word_t dx_ir_i,
    output logic            stall_o
);
    import core_pkg::*;
    import isa_pkg::*;

    opcode_t   fd_opcode;
    opcode_t   dx_opcode;
    reg_addr_t fd_src_a;
    reg_addr_t fd_src_b;
    reg_addr_t dx_rd;
    logic      dx_is_load;
    logic      match_a;
    logic      match_b;

    assign fd_opcode = fd_ir_i[OPCODE_HI:OPCODE_LO];
    assign dx_opcode = dx_ir_i[OPCODE_HI:OPCODE_LO];
    assign dx_rd     = dx_ir_i[RD_HI:RD_LO];

    assign fd_src_a = fd_ir_i[RS_HI:RS_LO];
    assign fd_src_b = (fd_opcode == OP_ALU) ? fd_ir_i[RT_HI:RT_LO] : fd_ir_i[RD_HI:RD_LO];

    assign dx_is_load = (dx_opcode == OP_LW) && (dx_rd != REG_ZERO);
    assign match_a    = (fd_src_a == dx_rd);
    // store data gets the loaded value later, in the memory stage
    assign match_b    = (fd_src_b == dx_rd) && (fd_opcode != OP_SW);

    assign stall_o = dx_is_load && (match_a || match_b);

endmodule

//--- src/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage #(
    parameter core_pkg::word_t RESET_PC = '0
) (
    input  logic            clock,
    input  logic            reset_i,
    input  logic            stall_i,
    input  logic            jump_i,
    input  core_pkg::word_t jump_target_i,
    input  core_pkg::word_t q_imem_i,
    output core_pkg::word_t address_imem_o,
    output core_pkg::word_t fd_pc_o,
    output core_pkg::word_t fd_ir_o
);
    import core_pkg::*;
    import isa_pkg::*;

    word_t pc;
    word_t pc_next;

    assign pc_next = jump_i ? jump_target_i : pc + word_t'(1);

    always_ff @(posedge clock) begin
        if (reset_i) begin
            pc      <= RESET_PC;
            fd_ir_o <= NOP_INSTR;
        end else if (jump_i) begin
            pc      <= pc_next;
            fd_ir_o <= NOP_INSTR;  // squash the word fetched this cycle
        end else if (!stall_i) begin
            pc      <= pc_next;
            fd_ir_o <= q_imem_i;
        end
    end

    assign address_imem_o = pc;
    assign fd_pc_o        = pc;  // address of fd_ir_o plus one

    // a load-use stall must hold the fetch address for exactly one cycle
    assert property (@(posedge clock) disable iff (reset_i)
        (stall_i && !jump_i) |=> $stable(pc));

endmodule

//--- src/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
    input  logic                clock,
    input  logic                reset_i,
    input  core_pkg::word_t     fd_pc_i,
    input  core_pkg::word_t     fd_ir_i,
    input  core_pkg::word_t     data_read_a_i,
    input  core_pkg::word_t     data_read_b_i,
    input  logic                flush_i,
    output core_pkg::reg_addr_t read_reg_a_o,
    output core_pkg::reg_addr_t read_reg_b_o,
    output logic                stall_o,
    output core_pkg::word_t     dx_pc_o,
    output core_pkg::word_t     dx_ir_o,
    output core_pkg::word_t     dx_a_o,
    output core_pkg::word_t     dx_b_o
);
    import core_pkg::*;
    import isa_pkg::*;

    logic  is_rtype;
    word_t ir_next;

    hazard_detect u_hazard_detect (
        .fd_ir_i (fd_ir_i),
        .dx_ir_i (dx_ir_o),
        .stall_o (stall_o)
    );

    assign is_rtype = (fd_ir_i[OPCODE_HI:OPCODE_LO] == OP_ALU);

    assign read_reg_a_o = fd_ir_i[RS_HI:RS_LO];
    // sw, branches and jr read rd through port b
    assign read_reg_b_o = is_rtype ? fd_ir_i[RT_HI:RT_LO] : fd_ir_i[RD_HI:RD_LO];

    assign ir_next = (stall_o || flush_i) ? NOP_INSTR : fd_ir_i;  // bubble or squash

    always_ff @(posedge clock) begin
        if (reset_i) begin
            dx_ir_o <= NOP_INSTR;
        end else begin
            dx_ir_o <= ir_next;
        end
    end

    always_ff @(posedge clock) begin
        dx_pc_o <= fd_pc_i;
        dx_a_o  <= data_read_a_i;
        dx_b_o  <= data_read_b_i;
    end

endmodule

//--- src/execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
    input  logic                clock,
    input  logic                reset_i,
    input  core_pkg::word_t     dx_pc_i,
    input  core_pkg::word_t     dx_ir_i,
    input  core_pkg::word_t     dx_a_i,
    input  core_pkg::word_t     dx_b_i,
    input  core_pkg::reg_addr_t xm_mw_rd_i,
    input  core_pkg::word_t     mw_data_i,
    input  logic                mw_wren_i,
    output logic                jump_o,
    output core_pkg::word_t     jump_target_o,
    output core_pkg::word_t     xm_ir_o,
    output core_pkg::word_t     xm_o_o,
    output core_pkg::word_t     xm_b_o
);
    import core_pkg::*;
    import isa_pkg::*;

    opcode_t   opcode;
    reg_addr_t src_b_num;
    word_t     op_a;
    word_t     op_b;
    word_t     imm_ext;
    word_t     target_ext;
    word_t     alu_a;
    word_t     alu_b;
    word_t     alu_result;
    alu_op_t   alu_op;
    logic      is_rtype;
    logic      is_branch;
    logic      use_imm;
    logic      ne;
    logic      lt;

    assign opcode    = dx_ir_i[OPCODE_HI:OPCODE_LO];
    assign is_rtype  = (opcode == OP_ALU);
    assign is_branch = (opcode == OP_BNE) || (opcode == OP_BLT);
    assign use_imm   = (opcode == OP_ADDI) || (opcode == OP_LW) || (opcode == OP_SW);
    assign src_b_num = is_rtype ? dx_ir_i[RT_HI:RT_LO] : dx_ir_i[RD_HI:RD_LO];

    assign imm_ext    = {{(WORD_W-IMM_HI-1){dx_ir_i[IMM_HI]}}, dx_ir_i[IMM_HI:IMM_LO]};
    assign target_ext = {{(WORD_W-TARGET_HI-1){1'b0}}, dx_ir_i[TARGET_HI:TARGET_LO]};

    operand_bypass u_bypass_a (
        .reg_val_i (dx_a_i),
        .reg_num_i (dx_ir_i[RS_HI:RS_LO]),
        .xm_ir_i   (xm_ir_o),
        .xm_o_i    (xm_o_o),
        .mw_rd_i   (xm_mw_rd_i),
        .mw_data_i (mw_data_i),
        .mw_wren_i (mw_wren_i),
        .operand_o (op_a)
    );

    operand_bypass u_bypass_b (
        .reg_val_i (dx_b_i),
        .reg_num_i (src_b_num),
        .xm_ir_i   (xm_ir_o),
        .xm_o_i    (xm_o_o),
        .mw_rd_i   (xm_mw_rd_i),
        .mw_data_i (mw_data_i),
        .mw_wren_i (mw_wren_i),
        .operand_o (op_b)
    );

    // branches compare rd against rs, so rd goes on side a
    assign alu_a  = is_branch ? op_b : op_a;
    assign alu_b  = use_imm ? imm_ext : (is_branch ? op_a : op_b);
    assign alu_op = is_rtype ? dx_ir_i[ALUOP_HI:ALUOP_LO] : ALU_ADD;

    alu u_alu (
        .operand_a_i (alu_a),
        .operand_b_i (alu_b),
        .alu_op_i    (alu_op),
        .shamt_i     (dx_ir_i[SHAMT_HI:SHAMT_LO]),
        .result_o    (alu_result),
        .not_equal_o (ne),
        .less_than_o (lt)
    );

    assign jump_o = (opcode == OP_J) || (opcode == OP_JAL) || (opcode == OP_JR) ||
                    ((opcode == OP_BNE) && ne) || ((opcode == OP_BLT) && lt);

    always_comb begin
        if (is_branch) begin
            jump_target_o = dx_pc_i + imm_ext;  // dx_pc_i is already pc+1
        end else if (opcode == OP_JR) begin
            jump_target_o = op_b;
        end else begin
            jump_target_o = target_ext;
        end
    end

    always_ff @(posedge clock) begin
        if (reset_i) begin
            xm_ir_o <= NOP_INSTR;
        end else begin
            xm_ir_o <= dx_ir_i;
        end
    end

    always_ff @(posedge clock) begin
        xm_o_o <= (opcode == OP_JAL) ? dx_pc_i : alu_result;  // jal links pc+1
        xm_b_o <= op_b;
    end

endmodule

//--- src/memory_stage.sv
`timescale 1ns/100ps

module memory_stage (
    input  logic                clock,
    input  logic                reset_i,
    input  core_pkg::word_t     xm_ir_i,
    input  core_pkg::word_t     xm_o_i,
    input  core_pkg::word_t     xm_b_i,
    input  core_pkg::word_t     q_dmem_i,
    output core_pkg::word_t     address_dmem_o,
    output core_pkg::word_t     data_dmem_o,
    output logic                wren_dmem_o,
    output core_pkg::reg_addr_t mw_rd_o,
    output core_pkg::word_t     mw_data_o,
    output logic                mw_wren_o
);
    import core_pkg::*;
    import isa_pkg::*;

    opcode_t   opcode;
    reg_addr_t xm_rd;
    reg_addr_t dest;
    logic      writes_reg;

    assign opcode = xm_ir_i[OPCODE_HI:OPCODE_LO];
    assign xm_rd  = xm_ir_i[RD_HI:RD_LO];
    assign dest   = (opcode == OP_JAL) ? REG_LINK : xm_rd;

    assign writes_reg = (opcode == OP_ALU) || (opcode == OP_ADDI) ||
                        (opcode == OP_JAL) || (opcode == OP_LW);

    assign address_dmem_o = xm_o_i;
    assign wren_dmem_o    = (opcode == OP_SW);
    // lw directly ahead of sw delivers the store data here
    assign data_dmem_o    = (mw_wren_o && (mw_rd_o == xm_rd) && (xm_rd != REG_ZERO)) ?
                            mw_data_o : xm_b_i;

    always_ff @(posedge clock) begin
        if (reset_i) begin
            mw_wren_o <= 1'b0;
        end else begin
            mw_wren_o <= writes_reg && (dest != REG_ZERO);
        end
    end

    always_ff @(posedge clock) begin
        mw_rd_o   <= dest;
        mw_data_o <= (opcode == OP_LW) ? q_dmem_i : xm_o_i;
    end

    // stores only ever come from an sw reaching XM, with known data
    assert property (@(posedge clock) disable iff (reset_i)
        wren_dmem_o |-> (xm_ir_i[OPCODE_HI:OPCODE_LO] == OP_SW) && !$isunknown(data_dmem_o));

endmodule

//--- src/reg_file.sv
`timescale 1ns/100ps

module reg_file (
    input  logic                clock,
    input  logic                reset_i,
    input  core_pkg::reg_addr_t read_reg_a_i,
    input  core_pkg::reg_addr_t read_reg_b_i,
    input  core_pkg::reg_addr_t write_reg_i,
    input  core_pkg::word_t     write_data_i,
    input  logic                write_en_i,
    output core_pkg::word_t     data_read_a_o,
    output core_pkg::word_t     data_read_b_o
);
    import core_pkg::*;

    word_t regs [NUM_REGS];
    logic  write_ok;

    assign write_ok = write_en_i && (write_reg_i != '0);  // r0 stays zero

    always_ff @(posedge clock) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_ok) begin
            regs[write_reg_i] <= write_data_i;
        end
    end

    // same-cycle write goes straight to the read ports
    assign data_read_a_o = (write_ok && (write_reg_i == read_reg_a_i)) ?
                           write_data_i : regs[read_reg_a_i];
    assign data_read_b_o = (write_ok && (write_reg_i == read_reg_b_i)) ?
                           write_data_i : regs[read_reg_b_i];

    assert property (@(posedge clock) disable iff (reset_i)
        (read_reg_a_i == '0) |-> (data_read_a_o == '0));
    assert property (@(posedge clock) disable iff (reset_i)
        (read_reg_b_i == '0) |-> (data_read_b_o == '0));

endmodule

//--- src/cpu_core.sv
`timescale 1ns/100ps

module cpu_core #(
    parameter core_pkg::word_t RESET_PC = '0
) (
    input  logic            clock,
    input  logic            reset_i,
    input  core_pkg::word_t q_imem_i,
    input  core_pkg::word_t q_dmem_i,
    output core_pkg::word_t address_imem_o,
    output core_pkg::word_t address_dmem_o,
    output core_pkg::word_t data_dmem_o,
    output logic            wren_dmem_o
);
    import core_pkg::*;

    logic      stall;
    logic      jump;
    word_t     jump_target;
    word_t     fd_pc;
    word_t     fd_ir;
    reg_addr_t read_reg_a;
    reg_addr_t read_reg_b;
    word_t     data_read_a;
    word_t     data_read_b;
    word_t     dx_pc;
    word_t     dx_ir;
    word_t     dx_a;
    word_t     dx_b;
    word_t     xm_ir;
    word_t     xm_o;
    word_t     xm_b;
    reg_addr_t mw_rd;
    word_t     mw_data;
    logic      mw_wren;

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
        .clock          (clock),
        .reset_i        (reset_i),
        .stall_i        (stall),
        .jump_i         (jump),
        .jump_target_i  (jump_target),
        .q_imem_i       (q_imem_i),
        .address_imem_o (address_imem_o),
        .fd_pc_o        (fd_pc),
        .fd_ir_o        (fd_ir)
    );

    decode_stage u_decode (
        .clock         (clock),
        .reset_i       (reset_i),
        .fd_pc_i       (fd_pc),
        .fd_ir_i       (fd_ir),
        .data_read_a_i (data_read_a),
        .data_read_b_i (data_read_b),
        .flush_i       (jump),  // second squash slot
        .read_reg_a_o  (read_reg_a),
        .read_reg_b_o  (read_reg_b),
        .stall_o       (stall),
        .dx_pc_o       (dx_pc),
        .dx_ir_o       (dx_ir),
        .dx_a_o        (dx_a),
        .dx_b_o        (dx_b)
    );

    execute_stage u_execute (
        .clock         (clock),
        .reset_i       (reset_i),
        .dx_pc_i       (dx_pc),
        .dx_ir_i       (dx_ir),
        .dx_a_i        (dx_a),
        .dx_b_i        (dx_b),
        .xm_mw_rd_i    (mw_rd),
        .mw_data_i     (mw_data),
        .mw_wren_i     (mw_wren),
        .jump_o        (jump),
        .jump_target_o (jump_target),
        .xm_ir_o       (xm_ir),
        .xm_o_o        (xm_o),
        .xm_b_o        (xm_b)
    );

    memory_stage u_memory (
        .clock          (clock),
        .reset_i        (reset_i),
        .xm_ir_i        (xm_ir),
        .xm_o_i         (xm_o),
        .xm_b_i         (xm_b),
        .q_dmem_i       (q_dmem_i),
        .address_dmem_o (address_dmem_o),
        .data_dmem_o    (data_dmem_o),
        .wren_dmem_o    (wren_dmem_o),
        .mw_rd_o        (mw_rd),
        .mw_data_o      (mw_data),
        .mw_wren_o      (mw_wren)
    );

    reg_file u_reg_file (
        .clock         (clock),
        .reset_i       (reset_i),
        .read_reg_a_i  (read_reg_a),
        .read_reg_b_i  (read_reg_b),
        .write_reg_i   (mw_rd),
        .write_data_i  (mw_data),
        .write_en_i    (mw_wren),
        .data_read_a_o (data_read_a),
        .data_read_b_o (data_read_b)
    );

endmodule

//--- testbench/tb_cpu_core.sv
`timescale 1ns/100ps

module tb_cpu_core;
    import core_pkg::*;
    import isa_pkg::*;

    localparam int    CLK_PERIOD = 20;
    localparam word_t RESET_PC   = 32'h0000_0010;
    localparam int    NUM_TESTS  = 6;

    logic  clock;
    logic  reset_i;
    word_t q_imem_i;
    word_t q_dmem_i;
    word_t address_imem_o;
    word_t address_dmem_o;
    word_t data_dmem_o;
    logic  wren_dmem_o;

    word_t       imem [256];
    word_t       dmem [256];
    word_t       model_regs [32];  // architectural registers as the program runs
    word_t       model_mem [256];
    word_t       exp_addr [256];
    word_t       exp_data [256];
    int          exp_test [256];
    int          test_errs [8];
    int          n_exp;
    int          store_idx;
    int          stray_errs;
    int          tests_passed;
    int          tests_failed;
    int          errors;
    int          pc_asm;
    int          prog_len;
    logic        prog_ready;
    logic [31:0] rng;

    cpu_core #(.RESET_PC(RESET_PC)) u_dut (
        .clock          (clock),
        .reset_i        (reset_i),
        .q_imem_i       (q_imem_i),
        .q_dmem_i       (q_dmem_i),
        .address_imem_o (address_imem_o),
        .address_dmem_o (address_dmem_o),
        .data_dmem_o    (data_dmem_o),
        .wren_dmem_o    (wren_dmem_o)
    );

    initial clock = 1'b0;
    always #(CLK_PERIOD / 2) clock = ~clock;

    assign q_imem_i = imem[address_imem_o[7:0]];
    assign q_dmem_i = dmem[address_dmem_o[7:0]];  // same-cycle read

    always @(posedge clock) begin
        if (wren_dmem_o === 1'b1) begin
            dmem[address_dmem_o[7:0]] <= data_dmem_o;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int rand_imm();
        rng = lcg_next(rng);
        return int'(rng[31:15]);  // 17 bits, sign comes from bit 16
    endfunction

    function automatic int rand_shamt();
        rng = lcg_next(rng);
        return int'(rng[20:16]);
    endfunction

    function automatic word_t fill_word(input int addr);
        return 32'hc0de_0000 ^ (word_t'(addr) * 32'h0001_0101);
    endfunction

    function automatic word_t sext17(input int imm);
        logic [16:0] f;
        f = 17'(imm);
        return {{15{f[16]}}, f};
    endfunction

    function automatic word_t enc_rtype(input int rd, input int rs, input int rt,
                                        input int shamt, input alu_op_t op);
        return {OP_ALU, 5'(rd), 5'(rs), 5'(rt), 5'(shamt), op, 2'b00};
    endfunction

    function automatic word_t enc_itype(input opcode_t op, input int rd, input int rs,
                                        input int imm);
        return {op, 5'(rd), 5'(rs), 17'(imm)};
    endfunction

    function automatic word_t enc_jtype(input opcode_t op, input int target);
        return {op, 27'(target)};
    endfunction

    function automatic string test_name(input int t);
        case (t)
            1:       return "reset";
            2:       return "alu and bypass";
            3:       return "load-use stall";
            4:       return "branches";
            5:       return "jumps";
            6:       return "register zero";
            default: return "unknown";
        endcase
    endfunction

    task automatic emit(input word_t w);
        imem[8'(pc_asm)] = w;
        pc_asm++;
        if (pc_asm > prog_len) prog_len = pc_asm;
    endtask

    task automatic write_model(input int rd, input word_t v);
        if (rd != 0) model_regs[5'(rd)] = v;  // r0 discards writes
    endtask

    task automatic add_expect(input word_t addr, input word_t data, input int t);
        exp_addr[8'(n_exp)] = addr;
        exp_data[8'(n_exp)] = data;
        exp_test[8'(n_exp)] = t;
        n_exp++;
    endtask

    task automatic asm_alu(input int rd, input int rs, input int rt, input int shamt,
                           input alu_op_t op);
        word_t a;
        word_t b;
        word_t r;
        a = model_regs[5'(rs)];
        b = model_regs[5'(rt)];
        case (op)
            ALU_ADD: r = a + b;
            ALU_SUB: r = a - b;
            ALU_AND: r = a & b;
            ALU_OR:  r = a | b;
            ALU_SLL: r = a << 5'(shamt);
            ALU_SRA: r = word_t'($signed(a) >>> 5'(shamt));
            default: r = '0;
        endcase
        emit(enc_rtype(rd, rs, rt, shamt, op));
        write_model(rd, r);
    endtask

    task automatic asm_addi(input int rd, input int rs, input int imm);
        emit(enc_itype(OP_ADDI, rd, rs, imm));
        write_model(rd, model_regs[5'(rs)] + sext17(imm));
    endtask

    task automatic asm_lw(input int rd, input int rs, input int imm);
        word_t addr;
        addr = model_regs[5'(rs)] + sext17(imm);
        emit(enc_itype(OP_LW, rd, rs, imm));
        write_model(rd, model_mem[addr[7:0]]);
    endtask

    // live is low for a store on a path that must not execute
    task automatic asm_sw(input int rd, input int rs, input int imm, input logic live,
                          input int t);
        word_t addr;
        emit(enc_itype(OP_SW, rd, rs, imm));
        if (live) begin
            addr = model_regs[5'(rs)] + sext17(imm);
            model_mem[addr[7:0]] = model_regs[5'(rd)];
            add_expect(addr, model_regs[5'(rd)], t);
        end
    endtask

    task automatic asm_branch(input opcode_t op, input int rd, input int rs, input int imm,
                              output logic taken);
        word_t a;
        word_t b;
        a = model_regs[5'(rd)];
        b = model_regs[5'(rs)];
        taken = (op == OP_BNE) ? (a != b) : ($signed(a) < $signed(b));
        emit(enc_itype(op, rd, rs, imm));
    endtask

    task automatic build_program();
        logic taken;
        int   base;
        pc_asm   = int'(RESET_PC);
        prog_len = pc_asm;
        n_exp    = 0;
        rng      = 32'h76ad_fb3d;
        for (int i = 0; i < 256; i++) begin
            imem[8'(i)]      = NOP_INSTR;
            dmem[8'(i)]      <= fill_word(i);
            model_mem[8'(i)] = fill_word(i);
        end
        for (int i = 0; i < 32; i++) model_regs[5'(i)] = '0;
        // back-to-back chain, each result stored right away
        asm_addi(1, 0, rand_imm());
        asm_addi(2, 0, rand_imm());
        asm_alu(3, 1, 2, 0, ALU_ADD);
        asm_sw(3, 0, 'h40, 1'b1, 2);
        asm_alu(4, 3, 1, 0, ALU_SUB);
        asm_sw(4, 0, 'h41, 1'b1, 2);
        asm_alu(5, 4, 2, 0, ALU_AND);
        asm_sw(5, 0, 'h42, 1'b1, 2);
        asm_alu(6, 5, 3, 0, ALU_OR);
        asm_sw(6, 0, 'h43, 1'b1, 2);
        asm_alu(7, 6, 0, rand_shamt(), ALU_SLL);
        asm_sw(7, 0, 'h44, 1'b1, 2);
        asm_alu(8, 2, 0, rand_shamt(), ALU_SRA);
        asm_sw(8, 0, 'h45, 1'b1, 2);
        asm_addi(9, 8, rand_imm());
        asm_sw(9, 0, 'h46, 1'b1, 2);
        asm_alu(10, 1, 9, 0, ALU_ADD);
        asm_sw(10, 0, 'h47, 1'b1, 2);
        // load followed by dependent use
        asm_addi(11, 0, 'h1234);
        asm_sw(11, 0, 'h50, 1'b1, 3);
        asm_lw(12, 0, 'h50);
        asm_alu(13, 12, 11, 0, ALU_ADD);
        asm_sw(13, 0, 'h51, 1'b1, 3);
        asm_lw(14, 0, 'h51);
        asm_sw(14, 0, 'h52, 1'b1, 3);  // store data straight from the load
        asm_lw(15, 0, 'h60);
        asm_alu(16, 15, 15, 0, ALU_ADD);
        asm_sw(16, 0, 'h53, 1'b1, 3);
        // branches, taken and not taken
        asm_addi(1, 0, 5);
        asm_addi(2, 0, -3);
        asm_branch(OP_BNE, 1, 2, 2, taken);
        asm_sw(1, 0, 'h70, !taken, 4);
        asm_sw(2, 0, 'h71, !taken, 4);
        asm_sw(1, 0, 'h72, 1'b1, 4);
        asm_branch(OP_BNE, 1, 1, 2, taken);
        asm_sw(1, 0, 'h73, !taken, 4);
        asm_sw(2, 0, 'h74, !taken, 4);
        asm_branch(OP_BLT, 2, 1, 3, taken);  // third skipped store is past the squash
        asm_sw(1, 0, 'h75, !taken, 4);
        asm_sw(1, 0, 'h76, !taken, 4);
        asm_sw(1, 0, 'h77, !taken, 4);
        asm_branch(OP_BLT, 1, 2, 2, taken);
        asm_sw(2, 0, 'h78, !taken, 4);
        asm_sw(1, 0, 'h79, !taken, 4);
        // j over three stores
        base = pc_asm;
        emit(enc_jtype(OP_J, base + 4));
        asm_sw(1, 0, 'h80, 1'b0, 5);
        asm_sw(1, 0, 'h81, 1'b0, 5);
        asm_sw(1, 0, 'h82, 1'b0, 5);
        asm_sw(2, 0, 'h83, 1'b1, 5);
        // jal to a subroutine at base+5, jr back to base+1
        base = pc_asm;
        emit(enc_jtype(OP_JAL, base + 5));
        write_model(31, word_t'(pc_asm));
        pc_asm = base + 5;
        asm_sw(31, 0, 'h84, 1'b1, 5);
        emit(enc_itype(OP_JR, 31, 0, 0));
        asm_sw(1, 0, 'h85, 1'b0, 5);
        asm_sw(1, 0, 'h86, 1'b0, 5);
        pc_asm = base + 1;
        asm_sw(1, 0, 'h87, 1'b1, 5);
        emit(enc_jtype(OP_J, base + 9));
        asm_sw(1, 0, 'h88, 1'b0, 5);
        asm_sw(1, 0, 'h89, 1'b0, 5);
        pc_asm = base + 9;
        // r0 stays zero
        asm_addi(0, 0, 123);
        asm_sw(0, 0, 'h90, 1'b1, 6);
        asm_alu(0, 1, 2, 0, ALU_ADD);
        asm_alu(18, 0, 1, 0, ALU_OR);
        asm_sw(18, 0, 'h91, 1'b1, 6);
        asm_sw(0, 0, 'h92, 1'b1, 6);
        emit(enc_jtype(OP_J, pc_asm));  // park here
    endtask

    task automatic report_test(input int t);
        if (test_errs[3'(t)] == 0) begin
            tests_passed++;
            $display("test %0d %s: passed", t, test_name(t));
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", t, test_name(t), test_errs[3'(t)]);
        end
    endtask

    task automatic check_store(input word_t addr, input word_t data);
        int t;
        if (store_idx >= n_exp) begin
            $display("unexpected store of %h to address %h at %0t", data, addr, $time);
            stray_errs++;
        end else begin
            t = exp_test[8'(store_idx)];
            if (addr !== exp_addr[8'(store_idx)]) begin
                $display("Fail %0t: address_dmem_o got %h expected %h",
                         $time, addr, exp_addr[8'(store_idx)]);
                test_errs[3'(t)]++;
            end
            if (data !== exp_data[8'(store_idx)]) begin
                $display("Fail %0t: data_dmem_o got %h expected %h",
                         $time, data, exp_data[8'(store_idx)]);
                test_errs[3'(t)]++;
            end
            store_idx++;
            if (store_idx == n_exp || exp_test[8'(store_idx)] != t) report_test(t);
        end
    endtask

    always @(negedge clock) begin
        if (wren_dmem_o === 1'b1) check_store(address_dmem_o, data_dmem_o);
    end

    initial begin
        reset_i      = 1'b1;
        prog_ready   = 1'b0;
        store_idx    = 0;
        stray_errs   = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int t = 0; t < 8; t++) test_errs[3'(t)] = 0;
        build_program();
        prog_ready = 1'b1;
        repeat (2) begin
            @(negedge clock);
            if (wren_dmem_o !== 1'b0) begin
                $display("Fail %0t: wren_dmem_o got %b expected 0", $time, wren_dmem_o);
                test_errs[1]++;
            end
        end
        reset_i = 1'b0;
        if (address_imem_o !== RESET_PC) begin
            $display("Fail %0t: address_imem_o got %h expected %h",
                     $time, address_imem_o, RESET_PC);
            test_errs[1]++;
        end
        @(negedge clock);
        if (wren_dmem_o !== 1'b0) begin
            $display("Fail %0t: wren_dmem_o got %b expected 0", $time, wren_dmem_o);
            test_errs[1]++;
        end
        report_test(1);
        wait (store_idx == n_exp);
        repeat (10) @(negedge clock);  // catch stray stores after the last one
        errors = stray_errs;
        for (int t = 1; t <= NUM_TESTS; t++) errors += test_errs[3'(t)];
        $display("tests passed %0d, failed %0d, errors %0d, stores %0d",
                 tests_passed, tests_failed, errors, store_idx);
        if (errors == 0 && tests_failed == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // run length scales with the program size
    initial begin
        wait (prog_ready);
        #(((prog_len - int'(RESET_PC)) * 4 + 40) * CLK_PERIOD);
        $display("timeout with %0d of %0d expected stores seen", store_idx, n_exp);
        $display("sim failed");
        $finish;
    end

endmodule

//--- pipe_cpu.f
src/core_pkg.sv
src/isa_pkg.sv
src/alu.sv
src/operand_bypass.sv
src/hazard_detect.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/reg_file.sv
src/cpu_core.sv
testbench/tb_cpu_core.sv

//--- run_sim.sh
#!/bin/sh
# build and run the pipe_cpu testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_cpu_core -Mdir obj_dir -f pipe_cpu.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_cpu_core)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
